// ==== src.f ====
calc_pkg.sv
calc_control.sv
operand_regs.sv
calc_alu.sv
bcd_converter.sv
calc_top.sv
tb_calc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_calc
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_calc.sv ====
`timescale 1ns/1ns

module tb_calc;
    import calc_pkg::*;

    localparam int N_RANDOM        = 24;
    localparam int N_RANDOM_SUB    = 8;
    localparam int N_OPS           = N_RANDOM + N_RANDOM_SUB + 9;
    localparam int WATCHDOG_CYCLES = 16 + N_OPS * 40 + 1000;

    logic         clk;
    logic         rst;
    logic         key_valid;
    logic [3:0]   key;
    logic [15:0]  ans;
    logic         negative;
    bcd_digits_t  digits;
    logic         bcd_valid;

    int           errors;
    int           checks;
    calc_result_t expected_q[$];
    calc_result_t last_result;

    calc_top u_calc_top (
        .clk       (clk),
        .rst       (rst),
        .key_valid (key_valid),
        .key       (key),
        .ans       (ans),
        .negative  (negative),
        .digits    (digits),
        .bcd_valid (bcd_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // Reference model

    function automatic calc_result_t expected_result(input op_t kind, input int a, input int b);
        calc_result_t r;
        int           full;
        case (kind)
            OP_PLUS:  full = a + b;
            OP_MINUS: full = a - b;
            OP_TIMES: full = a * b;
            default:  full = 0;
        endcase
        r.negative = (full < 0);
        r.value    = 16'((full < 0) ? -full : full);
        return r;
    endfunction

    function automatic bcd_digits_t decimal_digits(input int value);
        bcd_digits_t d;
        d.thousands = 4'((value / 1000) % 10);
        d.hundreds  = 4'((value / 100) % 10);
        d.tens      = 4'((value / 10) % 10);
        d.ones      = 4'(value % 10);
        return d;
    endfunction

    function automatic logic [3:0] op_key(input op_t kind);
        case (kind)
            OP_PLUS:  return KEY_PLUS;
            OP_MINUS: return KEY_MINUS;
            default:  return KEY_TIMES;
        endcase
    endfunction

    ////////////////////
    // Key sequencing

    task automatic press_key(input logic [3:0] code);
        @(posedge clk);
        key_valid <= 1'b1;
        key       <= code;
        @(posedge clk);
        key_valid <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // Answer must hold until the strobe is sampled, then update on that edge
    task automatic press_equals(input calc_result_t r);
        expected_q.push_back(r);
        @(posedge clk);
        key_valid <= 1'b1;
        key       <= KEY_EQUALS;
        @(negedge clk);
        if (ans !== last_result.value)
        begin
            errors++;
            $display("Fail at %0t: ans changed before equals was sampled", $time);
        end
        @(posedge clk);
        key_valid <= 1'b0;
        @(negedge clk);
        if (ans !== r.value || negative !== r.negative)
        begin
            errors++;
            $display("Fail at %0t: ans %0d neg %0b one cycle after equals, expected %0d neg %0b",
                     $time, ans, negative, r.value, r.negative);
        end
        last_result = r;
    endtask

    task automatic wait_for_display();
        while (expected_q.size() != 0)
            @(posedge clk);
    endtask

    task automatic run_operation(input op_t kind, input int a, input int b);
        press_key(4'(a / 10));
        press_key(4'(a % 10));
        press_key(op_key(kind));
        press_key(4'(b / 10));
        press_key(4'(b % 10));
        press_equals(expected_result(kind, a, b));
        wait_for_display();
    endtask

    // Key that must leave the shown answer and the display untouched
    task automatic press_checked(input logic [3:0] code);
        press_key(code);
        @(negedge clk);
        if (ans !== last_result.value || negative !== last_result.negative || bcd_valid !== 1'b1)
        begin
            errors++;
            $display("Fail at %0t: key %0d disturbed the answer or the display", $time, code);
        end
    endtask

    task automatic run_illegal_keys();
        press_checked(KEY_PLUS);
        press_checked(KEY_EQUALS);
        press_checked(4'd14);
        press_checked(4'd15);
        press_checked(4'd4);
        // Equals and operator while operand A is incomplete
        press_checked(KEY_EQUALS);
        press_checked(KEY_TIMES);
        press_checked(4'd7);
        press_checked(KEY_EQUALS);
        press_checked(KEY_MINUS);
        press_checked(4'd8);
        press_checked(KEY_PLUS);
        press_checked(KEY_EQUALS);
        press_checked(4'd3);
        press_equals(expected_result(OP_MINUS, 47, 83));
        wait_for_display();
    endtask

    ////////////////////
    // Main sequence

    initial
    begin
        op_t kind;
        int  a;
        int  b;
        void'($urandom(49473));
        errors      = 0;
        checks      = 0;
        last_result = '0;
        rst         = 1'b1;
        key_valid   = 1'b0;
        key         = 4'd0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (ans !== 16'd0 || negative !== 1'b0 || digits !== '0 || bcd_valid !== 1'b0)
        begin
            errors++;
            $display("Fail at %0t: outputs not cleared after reset", $time);
        end

        run_operation(OP_TIMES, 99, 99);
        run_operation(OP_PLUS, 0, 0);
        run_operation(OP_PLUS, 99, 99);
        run_operation(OP_MINUS, 12, 57);
        run_operation(OP_MINUS, 57, 12);
        run_operation(OP_MINUS, 33, 33);
        run_operation(OP_MINUS, 0, 99);
        run_operation(OP_TIMES, 9, 9);
        run_illegal_keys();

        for (int i = 0; i < N_RANDOM; i++)
        begin
            if ($urandom_range(1) == 0)
                kind = OP_PLUS;
            else
                kind = OP_TIMES;
            a    = int'($urandom_range(99));
            b    = int'($urandom_range(99));
            run_operation(kind, a, b);
        end
        for (int i = 0; i < N_RANDOM_SUB; i++)
        begin
            a = int'($urandom_range(99));
            b = int'($urandom_range(99));
            run_operation(OP_MINUS, a, b);
        end

        repeat (4) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    ////////////////////
    // Compare on each finished conversion

    initial
    begin
        calc_result_t exp_r;
        bcd_digits_t  exp_d;
        forever
        begin
            @(posedge bcd_valid);
            @(negedge clk);
            if (expected_q.size() == 0)
            begin
                errors++;
                $display("Fail at %0t: conversion finished with no answer pending", $time);
            end
            else
            begin
                exp_r = expected_q.pop_front();
                exp_d = decimal_digits(int'(exp_r.value));
                checks++;
                if (ans !== exp_r.value || negative !== exp_r.negative)
                begin
                    errors++;
                    $display("Fail at %0t: ans %0d neg %0b, expected %0d neg %0b",
                             $time, ans, negative, exp_r.value, exp_r.negative);
                end
                if (digits !== exp_d)
                begin
                    errors++;
                    $display("Fail at %0t: digits %h, expected %h", $time, digits, exp_d);
                end
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the calculator stopped answering", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== calc_top.sv ====
`timescale 1ns/1ns

module calc_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  key_valid,
    input  logic [3:0]            key,
    output logic [15:0]           ans,
    output logic                  negative,
    output calc_pkg::bcd_digits_t digits,
    output logic                  bcd_valid
);
    import calc_pkg::*;

    logic          digit_load;
    entry_state_t  entry_slot;
    logic          compute;
    op_t           op;
    operand_pair_t operands;
    calc_result_t  result;
    logic          result_load;

    ////////////////////
    // Key entry

    calc_control u_calc_control (
        .clk        (clk),
        .rst        (rst),
        .key_valid  (key_valid),
        .key        (key),
        .digit_load (digit_load),
        .entry_slot (entry_slot),
        .compute    (compute),
        .op         (op)
    );

    operand_regs u_operand_regs (
        .clk        (clk),
        .rst        (rst),
        .digit_load (digit_load),
        .entry_slot (entry_slot),
        .key        (key),
        .operands   (operands)
    );

    ////////////////////
    // Answer and display form

    calc_alu u_calc_alu (
        .clk         (clk),
        .rst         (rst),
        .compute     (compute),
        .op          (op),
        .operands    (operands),
        .result      (result),
        .result_load (result_load)
    );

    bcd_converter u_bcd_converter (
        .clk       (clk),
        .rst       (rst),
        .start     (result_load),
        .value     (result.value),
        .digits    (digits),
        .bcd_valid (bcd_valid)
    );

    assign ans      = result.value;
    assign negative = result.negative;

endmodule

// ==== bcd_converter.sv ====
`timescale 1ns/1ns

module bcd_converter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [calc_pkg::ANS_W-1:0] value,
    output calc_pkg::bcd_digits_t      digits,
    output logic                       bcd_valid
);
    import calc_pkg::*;

    logic [ANS_W-1:0]        bin_reg;
    logic [4*BCD_DIGITS-1:0] scratch;
    logic [4*BCD_DIGITS-1:0] scratch_next;
    logic [4:0]              count;
    logic                    busy;

    ////////////////////
    // Add 3 then shift

    always_comb
    begin
        logic [4*BCD_DIGITS-1:0] adjusted;
        adjusted = scratch;
        for (int i = 0; i < BCD_DIGITS; i++)
        begin
            if (scratch[4*i +: 4] >= 4'd5)
                adjusted[4*i +: 4] = scratch[4*i +: 4] + 4'd3;
        end
        // Next binary bit enters at the bottom
        scratch_next = {adjusted[4*BCD_DIGITS-2:0], bin_reg[ANS_W-1]};
    end

    ////////////////////
    // Step sequencing

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bin_reg   <= '0;
            scratch   <= '0;
            count     <= '0;
            busy      <= 1'b0;
            digits    <= '0;
            bcd_valid <= 1'b0;
        end
        else if (start)
        begin
            // Also restarts a conversion in flight
            bin_reg   <= value;
            scratch   <= '0;
            count     <= '0;
            busy      <= 1'b1;
            bcd_valid <= 1'b0;
        end
        else if (busy)
        begin
            bin_reg <= {bin_reg[ANS_W-2:0], 1'b0};
            scratch <= scratch_next;
            count   <= count + 5'd1;
            if (count == 5'(ANS_W - 1))
            begin
                busy      <= 1'b0;
                digits    <= scratch_next;
                bcd_valid <= 1'b1;
            end
        end
    end

    // Published digits are decimal
    assert property (@(posedge clk) disable iff (rst)
        bcd_valid |-> (digits.thousands <= 4'd9) && (digits.hundreds <= 4'd9) &&
                      (digits.tens <= 4'd9) && (digits.ones <= 4'd9))
        else $error("BCD digit above 9");

endmodule

// ==== calc_alu.sv ====
`timescale 1ns/1ns

module calc_alu (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    compute,
    input  calc_pkg::op_t           op,
    input  calc_pkg::operand_pair_t operands,
    output calc_pkg::calc_result_t  result,
    output logic                    result_load
);
    import calc_pkg::*;

    logic [ANS_W-1:0] a_ext;
    logic [ANS_W-1:0] b_ext;
    calc_result_t     result_next;

    assign a_ext = ANS_W'(operands.a);
    assign b_ext = ANS_W'(operands.b);

    always_comb
    begin
        result_next = result;
        case (op)
            OP_PLUS:
            begin
                result_next.negative = 1'b0;
                result_next.value    = a_ext + b_ext;
            end
            OP_MINUS:
            begin
                // Magnitude plus sign
                result_next.negative = (a_ext < b_ext);
                result_next.value    = (a_ext < b_ext) ? (b_ext - a_ext) : (a_ext - b_ext);
            end
            OP_TIMES:
            begin
                result_next.negative = 1'b0;
                result_next.value    = a_ext * b_ext;
            end
            default:
                ;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            result      <= '0;
            result_load <= 1'b0;
        end
        else
        begin
            result_load <= compute;
            if (compute)
                result <= result_next;
        end
    end

    // Two-digit operands bound every answer, the product being the largest
    assert property (@(posedge clk) disable iff (rst)
        result.value <= ANS_W'(MAX_RESULT))
        else $error("answer above 99 * 99");

endmodule

// ==== operand_regs.sv ====
`timescale 1ns/1ns

module operand_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    digit_load,
    input  calc_pkg::entry_state_t  entry_slot,
    input  logic [3:0]              key,
    output calc_pkg::operand_pair_t operands
);
    import calc_pkg::*;

    logic [OPERAND_W-1:0] digit;
    logic [OPERAND_W-1:0] tens_value;

    assign digit      = OPERAND_W'(key);
    assign tens_value = digit * OPERAND_W'(10);

    ////////////////////
    // Operand accumulation

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            operands <= '0;
        end
        else if (digit_load)
        begin
            case (entry_slot)
                ST_A_TENS:
                    operands.a <= tens_value;
                ST_A_ONES:
                    operands.a <= operands.a + digit;
                ST_B_TENS:
                    operands.b <= tens_value;
                ST_B_ONES:
                    operands.b <= operands.b + digit;
                default:
                    ;
            endcase
        end
    end

    // Tens then ones keeps each operand two decimal digits wide
    assert property (@(posedge clk) disable iff (rst)
        (operands.a <= OPERAND_W'(99)) && (operands.b <= OPERAND_W'(99)))
        else $error("operand above 99");

endmodule

// ==== calc_control.sv ====
`timescale 1ns/1ns

module calc_control (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   key_valid,
    input  logic [3:0]             key,
    output logic                   digit_load,
    output calc_pkg::entry_state_t entry_slot,
    output logic                   compute,
    output calc_pkg::op_t          op
);
    import calc_pkg::*;

    entry_state_t state;
    entry_state_t state_next;
    op_t          op_next;

    ////////////////////
    // Key decode

    always_comb
    begin
        state_next = state;
        op_next    = op;
        digit_load = 1'b0;
        compute    = 1'b0;
        if (key_valid)
        begin
            if (key <= 4'd9)
            begin
                // Digit slots wrap from B ones back to A tens
                digit_load = 1'b1;
                state_next = entry_state_t'(state + 2'd1);
            end
            else
            begin
                case (key)
                    KEY_PLUS:
                        if (state == ST_B_TENS)
                            op_next = OP_PLUS;
                    KEY_MINUS:
                        if (state == ST_B_TENS)
                            op_next = OP_MINUS;
                    KEY_TIMES:
                        if (state == ST_B_TENS)
                            op_next = OP_TIMES;
                    KEY_EQUALS:
                        // Both operands complete and operator stored
                        if (state == ST_A_TENS && op != OP_NONE)
                        begin
                            compute = 1'b1;
                            op_next = OP_NONE;
                        end
                    default:
                        ;
                endcase
            end
        end
    end

    assign entry_slot = state;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= ST_A_TENS;
            op    <= OP_NONE;
        end
        else
        begin
            state <= state_next;
            op    <= op_next;
        end
    end

    // A held strobe would enter the same digit twice
    assert property (@(posedge clk) disable iff (rst)
        key_valid |=> !key_valid)
        else $error("key strobe held longer than one cycle");

endmodule

// ==== calc_pkg.sv ====
package calc_pkg;

    ////////////////////
    // Widths

    localparam int OPERAND_W  = 7;
    localparam int ANS_W      = 16;
    localparam int BCD_DIGITS = 4;

    // Largest possible answer, 99 times 99
    localparam int MAX_RESULT = 9801;

    ////////////////////
    // Key codes and states

    // Digits 0 to 9 arrive as raw values, 14 and 15 are ignored
    typedef enum logic [3:0] {
        KEY_PLUS   = 4'd10,
        KEY_MINUS  = 4'd11,
        KEY_TIMES  = 4'd12,
        KEY_EQUALS = 4'd13
    } key_code_t;

    // Slot that the next digit key fills
    typedef enum logic [1:0] {
        ST_A_TENS = 2'd0,
        ST_A_ONES = 2'd1,
        ST_B_TENS = 2'd2,
        ST_B_ONES = 2'd3
    } entry_state_t;

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_PLUS  = 2'd1,
        OP_MINUS = 2'd2,
        OP_TIMES = 2'd3
    } op_t;

    ////////////////////
    // Datapath bundles

    typedef struct packed {
        logic [OPERAND_W-1:0] a;
        logic [OPERAND_W-1:0] b;
    } operand_pair_t;

    typedef struct packed {
        logic             negative;
        logic [ANS_W-1:0] value;
    } calc_result_t;

    typedef struct packed {
        logic [3:0] thousands;
        logic [3:0] hundreds;
        logic [3:0] tens;
        logic [3:0] ones;
    } bcd_digits_t;

endpackage
